// File: include/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath width
`define EXU_XLEN 32

// local data memory size in words
`define EXU_MEM_WORDS 64

// load latency in cycles which must be 1 or more
`define EXU_LOAD_LAT 2

`endif

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  // what kind of work an issued op does
  typedef enum logic [3:0] {
    CLS_ALU    = 4'd0,
    CLS_BRANCH = 4'd1,
    CLS_JAL    = 4'd2,
    CLS_JALR   = 4'd3,
    CLS_LOAD   = 4'd4,
    CLS_STORE  = 4'd5,
    CLS_CSR    = 4'd6,
    CLS_ECALL  = 4'd7,
    CLS_MRET   = 4'd8
  } op_class_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_EQ  = 2'd0,
    BR_NE  = 2'd1,
    BR_LT  = 2'd2,
    BR_LTU = 2'd3
  } br_op_e;

  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } csr_op_e;

  // machine mode subset
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342
  } csr_addr_e;

  // environment call from M-mode
  localparam int unsigned MCAUSE_ECALL = 11;

endpackage

// File: hdl/exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

  import rv_isa_pkg::*;

  // decoded op as it enters execute
  typedef struct packed {
    op_class_e             op_class;
    alu_op_e               alu_op;
    br_op_e                br_op;
    csr_op_e               csr_op;
    csr_addr_e             csr_addr;
    logic [4:0]            rd;
    logic [`EXU_XLEN-1:0]  src1;
    logic [`EXU_XLEN-1:0]  src2;
    logic [`EXU_XLEN-1:0]  imm;
    logic [`EXU_XLEN-1:0]  pc;
  } issue_t;

  // one record per finished op
  typedef struct packed {
    logic [`EXU_XLEN-1:0]  pc;
    logic [4:0]            rd;
    logic [`EXU_XLEN-1:0]  wdata;
    logic                  redirect;
    logic [`EXU_XLEN-1:0]  npc;
  } retire_t;

endpackage

// File: hdl/pipe_slice.sv
`timescale 1ns/1ps

module pipe_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // take a new item when empty or draining
  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

endmodule

// File: hdl/exu_alu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_alu
  import rv_isa_pkg::*;
(
  input  alu_op_e               alu_op_i,
  input  logic [`EXU_XLEN-1:0]  a_i,
  input  logic [`EXU_XLEN-1:0]  b_i,
  output logic [`EXU_XLEN-1:0]  res_o
);

  localparam int XLEN = `EXU_XLEN;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      default:  res_o = '0;
    endcase
  end

endmodule

// File: hdl/exu_csr.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_csr
  import rv_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  commit_i,
  input  csr_op_e               op_i,
  input  csr_addr_e             addr_i,
  input  logic [`EXU_XLEN-1:0]  wdata_i,
  input  logic                  ecall_i,
  input  logic                  mret_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  output logic [`EXU_XLEN-1:0]  rdata_o,
  output logic [`EXU_XLEN-1:0]  mtvec_o,
  output logic [`EXU_XLEN-1:0]  mepc_o
);

  logic [`EXU_XLEN-1:0] mstatus_q, mtvec_q, mepc_q, mcause_q, mscratch_q;
  logic [`EXU_XLEN-1:0] new_val;

  always_comb begin
    case (addr_i)
      CSR_MSTATUS:  rdata_o = mstatus_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = mcause_q;
      CSR_MSCRATCH: rdata_o = mscratch_q;
      default:      rdata_o = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (op_i)
      CSR_RW:  new_val = wdata_i;
      CSR_RS:  new_val = rdata_o | wdata_i;
      default: new_val = rdata_o & ~wdata_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else if (commit_i) begin
      if (ecall_i) begin
        mepc_q   <= pc_i;
        mcause_q <= `EXU_XLEN'(MCAUSE_ECALL);
      end else if (mret_i) begin
        // MIE takes MPIE and MPIE is set
        mstatus_q[3] <= mstatus_q[7];
        mstatus_q[7] <= 1'b1;
      end else begin
        case (addr_i)
          CSR_MSTATUS:  mstatus_q  <= new_val;
          CSR_MTVEC:    mtvec_q    <= new_val;
          CSR_MEPC:     mepc_q     <= new_val;
          CSR_MCAUSE:   mcause_q   <= new_val;
          CSR_MSCRATCH: mscratch_q <= new_val;
          default:      mscratch_q <= mscratch_q;
        endcase
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

// File: hdl/exu_lsu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_lsu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  req_we_i,
  input  logic [`EXU_XLEN-1:0]  req_addr_i,
  input  logic [`EXU_XLEN-1:0]  req_wdata_i,
  output logic                  resp_valid_o,
  output logic [`EXU_XLEN-1:0]  rdata_o
);

  localparam int AW = $clog2(`EXU_MEM_WORDS);
  localparam int CW = $clog2(`EXU_LOAD_LAT + 1);

  logic [`EXU_XLEN-1:0] mem [`EXU_MEM_WORDS];
  logic [AW-1:0]        idx;
  logic [AW-1:0]        addr_q;
  logic                 busy_q;
  logic [CW-1:0]        cnt_q;
  logic                 accept;

  // word index wraps over the memory
  assign idx         = req_addr_i[2 +: AW];
  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  assign resp_valid_o = busy_q && (cnt_q == CW'(`EXU_LOAD_LAT));
  assign rdata_o      = mem[addr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (resp_valid_o) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (accept && !req_we_i) begin
      busy_q <= 1'b1;
      cnt_q  <= CW'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (accept && req_we_i) begin
      mem[idx] <= req_wdata_i;
    end
    if (accept && !req_we_i) begin
      addr_q <= idx;
    end
  end

endmodule

// File: hdl/exu_core.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_core
  import rv_isa_pkg::*;
  import exu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  op_valid_i,
  output logic                  op_ready_o,
  input  issue_t                op_i,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output retire_t               res_o,
  output alu_op_e               alu_op_o,
  output logic [`EXU_XLEN-1:0]  alu_a_o,
  output logic [`EXU_XLEN-1:0]  alu_b_o,
  input  logic [`EXU_XLEN-1:0]  alu_res_i,
  output logic                  csr_commit_o,
  output csr_op_e               csr_op_o,
  output csr_addr_e             csr_addr_o,
  output logic [`EXU_XLEN-1:0]  csr_wdata_o,
  output logic                  csr_ecall_o,
  output logic                  csr_mret_o,
  output logic [`EXU_XLEN-1:0]  csr_pc_o,
  input  logic [`EXU_XLEN-1:0]  csr_rdata_i,
  input  logic [`EXU_XLEN-1:0]  mtvec_i,
  input  logic [`EXU_XLEN-1:0]  mepc_i,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output logic                  req_we_o,
  output logic [`EXU_XLEN-1:0]  req_addr_o,
  output logic [`EXU_XLEN-1:0]  req_wdata_o,
  input  logic                  resp_valid_i,
  input  logic [`EXU_XLEN-1:0]  rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } mem_state_e;

  mem_state_e           state_q;
  logic [`EXU_XLEN-1:0] ldata_q;
  logic [`EXU_XLEN-1:0] link, br_target, mem_data, wdata_raw;
  logic                 is_load, is_mem, is_sys, br_taken;

  assign is_load = op_i.op_class == CLS_LOAD;
  assign is_mem  = is_load || op_i.op_class == CLS_STORE;
  assign is_sys  = op_i.op_class inside {CLS_CSR, CLS_ECALL, CLS_MRET};

  assign link      = op_i.pc + `EXU_XLEN'(4);
  assign br_target = op_i.pc + op_i.imm;

  // operand steering
  always_comb begin
    alu_op_o = ALU_ADD;
    alu_a_o  = op_i.src1;
    alu_b_o  = op_i.src2;
    case (op_i.op_class)
      CLS_ALU: alu_op_o = op_i.alu_op;
      CLS_BRANCH: begin
        case (op_i.br_op)
          BR_LT:   alu_op_o = ALU_SLT;
          BR_LTU:  alu_op_o = ALU_SLTU;
          default: alu_op_o = ALU_SUB;
        endcase
      end
      CLS_JAL: begin
        alu_a_o = op_i.pc;
        alu_b_o = op_i.imm;
      end
      // jalr and memory both take src1 + imm
      CLS_JALR, CLS_LOAD, CLS_STORE: alu_b_o = op_i.imm;
      default: alu_op_o = ALU_ADD;
    endcase
  end

  always_comb begin
    case (op_i.br_op)
      BR_EQ:   br_taken = alu_res_i == '0;
      BR_NE:   br_taken = alu_res_i != '0;
      default: br_taken = alu_res_i[0];
    endcase
  end

  // handshakes by memory state
  always_comb begin
    res_valid_o = 1'b0;
    op_ready_o  = 1'b0;
    req_valid_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (is_mem) begin
          req_valid_o = op_valid_i;
        end else begin
          res_valid_o = op_valid_i;
          op_ready_o  = res_ready_i;
        end
      end
      ST_WAIT: begin
        res_valid_o = resp_valid_i;
        op_ready_o  = resp_valid_i && res_ready_i;
      end
      default: begin
        res_valid_o = 1'b1;
        op_ready_o  = res_ready_i;
      end
    endcase
  end

  assign req_we_o    = op_i.op_class == CLS_STORE;
  assign req_addr_o  = alu_res_i;
  assign req_wdata_o = op_i.src2;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_valid_o && req_ready_i) begin
            state_q <= req_we_o ? ST_DONE : ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (resp_valid_i) begin
            state_q <= res_ready_i ? ST_IDLE : ST_DONE;
          end
        end
        default: begin
          if (res_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // load data held while retire stalls
  always_ff @(posedge clk) begin
    if (state_q == ST_WAIT && resp_valid_i) begin
      ldata_q <= rdata_i;
    end
  end

  assign mem_data = (state_q == ST_WAIT) ? rdata_i : ldata_q;

  // CSR and trap effects land with the retire transfer
  assign csr_commit_o = state_q == ST_IDLE && op_valid_i && res_ready_i && is_sys;
  assign csr_op_o     = op_i.csr_op;
  assign csr_addr_o   = op_i.csr_addr;
  assign csr_wdata_o  = op_i.src1;
  assign csr_ecall_o  = op_i.op_class == CLS_ECALL;
  assign csr_mret_o   = op_i.op_class == CLS_MRET;
  assign csr_pc_o     = op_i.pc;

  always_comb begin
    case (op_i.op_class)
      CLS_ALU:           wdata_raw = alu_res_i;
      CLS_JAL, CLS_JALR: wdata_raw = link;
      CLS_LOAD:          wdata_raw = mem_data;
      CLS_CSR:           wdata_raw = csr_rdata_i;
      default:           wdata_raw = '0;
    endcase
  end

  always_comb begin
    res_o.pc       = op_i.pc;
    res_o.rd       = op_i.rd;
    res_o.wdata    = (op_i.rd == 5'd0) ? '0 : wdata_raw;
    res_o.redirect = 1'b1;
    case (op_i.op_class)
      CLS_BRANCH: begin
        res_o.redirect = br_taken;
        res_o.npc      = br_taken ? br_target : link;
      end
      CLS_JAL, CLS_JALR: res_o.npc = alu_res_i;
      CLS_ECALL:         res_o.npc = mtvec_i;
      CLS_MRET:          res_o.npc = mepc_i;
      default: begin
        res_o.redirect = 1'b0;
        res_o.npc      = link;
      end
    endcase
  end

endmodule

// File: hdl/exu_top.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_top
  import rv_isa_pkg::*;
  import exu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  op_class_e             class_i,
  input  alu_op_e               alu_op_i,
  input  br_op_e                br_op_i,
  input  csr_op_e               csr_op_i,
  input  csr_addr_e             csr_addr_i,
  input  logic [4:0]            rd_i,
  input  logic [`EXU_XLEN-1:0]  src1_i,
  input  logic [`EXU_XLEN-1:0]  src2_i,
  input  logic [`EXU_XLEN-1:0]  imm_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [`EXU_XLEN-1:0]  out_pc_o,
  output logic [4:0]            out_rd_o,
  output logic [`EXU_XLEN-1:0]  out_wdata_o,
  output logic                  out_redirect_o,
  output logic [`EXU_XLEN-1:0]  out_npc_o
);

  issue_t               issue_in, issue_q;
  retire_t              retire_d, retire_q;
  logic                 op_valid, op_ready, res_valid, res_ready;
  alu_op_e              alu_op;
  logic [`EXU_XLEN-1:0] alu_a, alu_b, alu_res;
  logic                 csr_commit, csr_ecall, csr_mret;
  csr_op_e              csr_op;
  csr_addr_e            csr_addr;
  logic [`EXU_XLEN-1:0] csr_wdata, csr_pc, csr_rdata, mtvec, mepc;
  logic                 req_valid, req_ready, req_we, resp_valid;
  logic [`EXU_XLEN-1:0] req_addr, req_wdata, rdata;

  assign issue_in = '{op_class: class_i, alu_op: alu_op_i, br_op: br_op_i,
                      csr_op: csr_op_i, csr_addr: csr_addr_i, rd: rd_i,
                      src1: src1_i, src2: src2_i, imm: imm_i, pc: pc_i};

  pipe_slice #(.payload_t(issue_t)) u_issue_slice (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_data_i(issue_in),
    .out_valid_o(op_valid), .out_ready_i(op_ready), .out_data_o(issue_q)
  );

  exu_core u_core (
    .clk(clk), .rst(rst),
    .op_valid_i(op_valid), .op_ready_o(op_ready), .op_i(issue_q),
    .res_valid_o(res_valid), .res_ready_i(res_ready), .res_o(retire_d),
    .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_res_i(alu_res),
    .csr_commit_o(csr_commit), .csr_op_o(csr_op), .csr_addr_o(csr_addr),
    .csr_wdata_o(csr_wdata), .csr_ecall_o(csr_ecall), .csr_mret_o(csr_mret),
    .csr_pc_o(csr_pc), .csr_rdata_i(csr_rdata), .mtvec_i(mtvec), .mepc_i(mepc),
    .req_valid_o(req_valid), .req_ready_i(req_ready), .req_we_o(req_we),
    .req_addr_o(req_addr), .req_wdata_o(req_wdata),
    .resp_valid_i(resp_valid), .rdata_i(rdata)
  );

  exu_alu u_alu (.alu_op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .res_o(alu_res));

  exu_csr u_csr (
    .clk(clk), .rst(rst), .commit_i(csr_commit), .op_i(csr_op),
    .addr_i(csr_addr), .wdata_i(csr_wdata), .ecall_i(csr_ecall),
    .mret_i(csr_mret), .pc_i(csr_pc), .rdata_o(csr_rdata),
    .mtvec_o(mtvec), .mepc_o(mepc)
  );

  exu_lsu u_lsu (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_we_i(req_we),
    .req_addr_i(req_addr), .req_wdata_i(req_wdata),
    .resp_valid_o(resp_valid), .rdata_o(rdata)
  );

  pipe_slice #(.payload_t(retire_t)) u_retire_slice (
    .clk(clk), .rst(rst),
    .in_valid_i(res_valid), .in_ready_o(res_ready), .in_data_i(retire_d),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_data_o(retire_q)
  );

  assign out_pc_o       = retire_q.pc;
  assign out_rd_o       = retire_q.rd;
  assign out_wdata_o    = retire_q.wdata;
  assign out_redirect_o = retire_q.redirect;
  assign out_npc_o      = retire_q.npc;

endmodule

// File: tb/exu_asserts.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_asserts #(
  parameter int PW = 3 * `EXU_XLEN + 6
) (
  input logic          clk,
  input logic          rst,
  input logic          in_ready_i,
  input logic          out_valid_i,
  input logic          out_ready_i,
  input logic [PW-1:0] payload_i
);

  int unsigned fail_count;

  initial begin
    fail_count = 0;
  end

  // stalled record holds still
  property hold_under_stall;
    @(posedge clk) disable iff (rst)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(payload_i);
  endproperty

  property quiet_in_reset;
    @(posedge clk) rst |=> !out_valid_i;
  endproperty

  property ready_after_reset;
    @(posedge clk) $fell(rst) |-> in_ready_i;
  endproperty

  assert property (hold_under_stall)
    else begin
      fail_count++;
      $error("retire output changed or dropped while stalled");
    end
  assert property (quiet_in_reset)
    else begin
      fail_count++;
      $error("out_valid_o high during reset");
    end
  assert property (ready_after_reset)
    else begin
      fail_count++;
      $error("in_ready_o low when reset released");
    end

endmodule

// File: tb/exu_tb.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_tb
  import rv_isa_pkg::*;
  import exu_pkg::*;
();

  localparam int XLEN       = `EXU_XLEN;
  localparam int WORDS      = `EXU_MEM_WORDS;
  localparam int NUM_RAND   = 400;
  // memory is filled by a run of stores before the random ops
  localparam int NUM_OPS    = NUM_RAND + WORDS;
  localparam int MAX_CYCLES = NUM_OPS * (`EXU_LOAD_LAT + 4) * 4;

  logic            clk;
  logic            rst;
  logic            in_valid;
  logic            in_ready;
  op_class_e       cls;
  alu_op_e         alu_op;
  br_op_e          br_op;
  csr_op_e         csr_op;
  csr_addr_e       csr_addr;
  logic [4:0]      rd;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] pc;
  logic            out_valid;
  logic            out_ready;
  logic [XLEN-1:0] out_pc;
  logic [4:0]      out_rd;
  logic [XLEN-1:0] out_wdata;
  logic            out_redirect;
  logic [XLEN-1:0] out_npc;

  logic [31:0]     seed;
  logic [XLEN-1:0] mem_model [WORDS];
  // mstatus, mtvec, mepc, mcause, mscratch
  logic [XLEN-1:0] csr_model [5];
  retire_t         exp_q [$];
  int              errors;
  int              checks;
  int              issued;
  int              retired;
  int              cycles;

  exu_top uut (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid), .in_ready_o(in_ready),
    .class_i(cls), .alu_op_i(alu_op), .br_op_i(br_op), .csr_op_i(csr_op),
    .csr_addr_i(csr_addr), .rd_i(rd), .src1_i(src1), .src2_i(src2),
    .imm_i(imm), .pc_i(pc),
    .out_valid_o(out_valid), .out_ready_i(out_ready),
    .out_pc_o(out_pc), .out_rd_o(out_rd), .out_wdata_o(out_wdata),
    .out_redirect_o(out_redirect), .out_npc_o(out_npc)
  );

  bind exu_top exu_asserts u_asserts (
    .clk(clk), .rst(rst), .in_ready_i(in_ready_o),
    .out_valid_i(out_valid_o), .out_ready_i(out_ready_i),
    .payload_i({out_pc_o, out_rd_o, out_wdata_o, out_redirect_o, out_npc_o})
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // upper half only as the low LCG bits are weak
  function automatic int unsigned pick(int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return {16'd0, r[31:16]} % n;
  endfunction

  function automatic logic [XLEN-1:0] wide_value();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic csr_addr_e any_csr();
    csr_addr_e a;
    case (pick(5))
      0:       a = CSR_MSTATUS;
      1:       a = CSR_MTVEC;
      2:       a = CSR_MEPC;
      3:       a = CSR_MCAUSE;
      default: a = CSR_MSCRATCH;
    endcase
    return a;
  endfunction

  function automatic int slot_of(csr_addr_e a);
    int s;
    case (a)
      CSR_MSTATUS: s = 0;
      CSR_MTVEC:   s = 1;
      CSR_MEPC:    s = 2;
      CSR_MCAUSE:  s = 3;
      default:     s = 4;
    endcase
    return s;
  endfunction

  function automatic logic [XLEN-1:0] alu_model(alu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] fill;
    int              sh;
    sh   = int'(b & 32'h1f);
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a + ~b + 1;
      ALU_XOR:  r = a ^ b;
      ALU_OR:   r = a | b;
      ALU_AND:  r = a & b;
      // with differing signs the negative one is smaller
      ALU_SLT:  r = (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
      ALU_SLTU: r = XLEN'(a < b);
      ALU_SLL:  r = a << sh;
      ALU_SRL:  r = a >> sh;
      default:  r = (a >> sh) | fill;
    endcase
    return r;
  endfunction

  task automatic check(string what, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic score_output();
    retire_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("a retire record came out at %0t with nothing outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      check("pc", out_pc, e.pc);
      check("rd", XLEN'(out_rd), XLEN'(e.rd));
      check("wdata", out_wdata, e.wdata);
      check("redirect", XLEN'(out_redirect), XLEN'(e.redirect));
      check("npc", out_npc, e.npc);
    end
    retired++;
  endtask

  // draws one op, applies it to the model and drives it
  task automatic issue_next();
    op_class_e       c;
    alu_op_e         a_op;
    br_op_e          b_op;
    csr_op_e         c_op;
    csr_addr_e       ca;
    logic [4:0]      d;
    logic [XLEN-1:0] s1, s2, im, p, old;
    logic            taken;
    retire_t         e;
    int              k;
    c    = op_class_e'(pick(9));
    a_op = alu_op_e'(pick(10));
    b_op = br_op_e'(pick(4));
    c_op = csr_op_e'(pick(3));
    ca   = any_csr();
    d    = (pick(4) == 0) ? 5'd0 : 5'(pick(32));
    s1   = wide_value();
    s2   = (pick(3) == 0) ? s1 : wide_value();
    im   = wide_value();
    p    = wide_value() & ~32'h3;
    if (c == CLS_LOAD || c == CLS_STORE) begin
      s1 = XLEN'(pick(WORDS / 2)) << 2;
      im = XLEN'(pick(WORDS / 2)) << 2;
    end
    if (issued < WORDS) begin
      c  = CLS_STORE;
      s1 = XLEN'(issued) << 2;
      im = '0;
    end
    e.pc       = p;
    e.rd       = d;
    e.wdata    = '0;
    e.redirect = 1'b0;
    e.npc      = p + 4;
    case (c)
      CLS_ALU: e.wdata = alu_model(a_op, s1, s2);
      CLS_BRANCH: begin
        case (b_op)
          BR_EQ:   taken = s1 == s2;
          BR_NE:   taken = s1 != s2;
          BR_LT:   taken = $signed(s1) < $signed(s2);
          default: taken = s1 < s2;
        endcase
        e.redirect = taken;
        if (taken) begin
          e.npc = p + im;
        end
      end
      CLS_JAL, CLS_JALR: begin
        e.redirect = 1'b1;
        e.npc      = (c == CLS_JAL) ? p + im : s1 + im;
        e.wdata    = p + 4;
      end
      CLS_LOAD:  e.wdata = mem_model[((s1 + im) >> 2) % WORDS];
      CLS_STORE: mem_model[((s1 + im) >> 2) % WORDS] = s2;
      CLS_CSR: begin
        k       = slot_of(ca);
        old     = csr_model[k];
        e.wdata = old;
        case (c_op)
          CSR_RW:  csr_model[k] = s1;
          CSR_RS:  csr_model[k] = old | s1;
          default: csr_model[k] = old & ~s1;
        endcase
      end
      CLS_ECALL: begin
        e.redirect   = 1'b1;
        e.npc        = csr_model[1];
        csr_model[2] = p;
        csr_model[3] = XLEN'(MCAUSE_ECALL);
      end
      default: begin
        e.redirect      = 1'b1;
        e.npc           = csr_model[2];
        csr_model[0][3] = csr_model[0][7];
        csr_model[0][7] = 1'b1;
      end
    endcase
    if (d == 5'd0) begin
      e.wdata = '0;
    end
    exp_q.push_back(e);
    cls      <= c;
    alu_op   <= a_op;
    br_op    <= b_op;
    csr_op   <= c_op;
    csr_addr <= ca;
    rd       <= d;
    src1     <= s1;
    src2     <= s2;
    imm      <= im;
    pc       <= p;
    in_valid <= 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    logic in_fire;
    logic out_fire;
    bit   timed_out;
    seed      = 32'd42725;
    errors    = 0;
    checks    = 0;
    issued    = 0;
    retired   = 0;
    cycles    = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    cls       = CLS_ALU;
    alu_op    = ALU_ADD;
    br_op     = BR_EQ;
    csr_op    = CSR_RW;
    csr_addr  = CSR_MSTATUS;
    rd        = '0;
    src1      = '0;
    src2      = '0;
    imm       = '0;
    pc        = '0;
    out_ready = 1'b0;
    for (int i = 0; i < 5; i++) begin
      csr_model[i] = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    while (retired < NUM_OPS && !timed_out) begin
      // handshakes are read mid-cycle once settled
      @(negedge clk);
      in_fire  = in_valid && in_ready;
      out_fire = out_valid && out_ready;
      if (out_fire) begin
        score_output();
      end
      @(posedge clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        timed_out = 1'b1;
      end
      if (in_fire || !in_valid) begin
        if (issued < NUM_OPS && pick(4) != 0) begin
          issue_next();
          issued++;
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= pick(3) != 0;
    end
    if (timed_out) begin
      $display("timeout: stopped after %0d cycles with %0d of %0d ops retired",
               cycles, retired, NUM_OPS);
    end else begin
      // a stray record stays visible while the output is stalled
      out_ready <= 1'b0;
      repeat (4) @(negedge clk);
      check("trailing out_valid", XLEN'(out_valid), '0);
      check("retire count", XLEN'(retired), XLEN'(issued));
      check("outstanding records", XLEN'(exp_q.size()), '0);
    end
    errors += uut.u_asserts.fail_count;
    $display("checks %0d, errors %0d, issued %0d, retired %0d",
             checks, errors, issued, retired);
    if (errors == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/exu_pkg.sv
hdl/pipe_slice.sv
hdl/exu_alu.sv
hdl/exu_csr.sv
hdl/exu_lsu.sv
hdl/exu_core.sv
hdl/exu_top.sv
tb/exu_asserts.sv
tb/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module exu_tb -o exu_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/exu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  exit 0
fi
exit 1
